// ==== flist.f ====
+incdir+design
design/mem_pkg.sv
design/store_buffer.sv
design/ram_sequencer.sv
design/mem_arbiter.sv
design/mem_ctrl_top.sv
tests/tb_clock.sv
tests/ram_model.sv
tests/mem_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_ctrl_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/mem_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_ctrl_tb;

    localparam int RAM_AW       = 12;
    localparam int CYCLE_LIMIT  = 4000;
    localparam int RESULT_LIMIT = 100;
    localparam int QUIET_CYCLES = 40;

    logic clk;
    logic rst;

    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic                   ram_we;
    logic [`MEM_BYTE_W-1:0] ram_wdata;
    logic [`MEM_BYTE_W-1:0] ram_rdata;
    logic                   fetch_req;
    logic [`MEM_ADDR_W-1:0] fetch_pc;
    logic                   inst_valid;
    logic [`MEM_WORD_W-1:0] inst;
    logic                   load_start;
    mem_pkg::load_req_t     load_req;
    logic                   load_valid;
    logic [`MEM_WORD_W-1:0] load_data;
    logic                   store_push;
    mem_pkg::store_entry_t  store_entry;
    logic                   store_full;
    logic                   rollback;
    logic                   bd_we;
    logic [`MEM_ADDR_W-1:0] bd_addr;
    logic [`MEM_WORD_W-1:0] bd_data;

    int checks = 0;
    int errors = 0;
    int cycle_count = 0;

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ram_model #(.AW(RAM_AW)) ram (
        .clk     (clk),
        .addr    (ram_addr),
        .we      (ram_we),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata),
        .bd_we   (bd_we),
        .bd_addr (bd_addr),
        .bd_data (bd_data)
    );

    mem_ctrl_top dut (
        .clk         (clk),
        .rst         (rst),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .load_start  (load_start),
        .load_req    (load_req),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .store_push  (store_push),
        .store_entry (store_entry),
        .store_full  (store_full),
        .rollback    (rollback)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input logic [`MEM_WORD_W-1:0] exp,
                              input logic [`MEM_WORD_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // expected value straight from the RISC-V load rules
    task automatic check_op_result(input mem_pkg::mem_op_e op,
                                   input logic [3:0][`MEM_BYTE_W-1:0] raw,
                                   input logic [`MEM_WORD_W-1:0] got);
        logic [`MEM_WORD_W-1:0] exp;
        case (op)
            mem_pkg::OP_LB:  exp = 32'($signed(raw[0]));
            mem_pkg::OP_LBU: exp = 32'(raw[0]);
            mem_pkg::OP_LH:  exp = 32'($signed({raw[1], raw[0]}));
            mem_pkg::OP_LHU: exp = 32'({raw[1], raw[0]});
            default:         exp = raw;
        endcase
        check_word({"load_data ", op.name()}, exp, got);
    endtask

    function automatic logic [`MEM_WORD_W-1:0] ram_word(input logic [`MEM_ADDR_W-1:0] a);
        return {ram.mem[RAM_AW'(a + 3)], ram.mem[RAM_AW'(a + 2)],
                ram.mem[RAM_AW'(a + 1)], ram.mem[RAM_AW'(a)]};
    endfunction

    // bytes touched by an access of this width
    function automatic logic [`MEM_WORD_W-1:0] byte_mask(input mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: return 32'h0000_00ff;
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic issue_fetch(input logic [`MEM_ADDR_W-1:0] pc);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        next_cycle();
        fetch_req = 1'b0;
    endtask

    task automatic issue_load(input logic [`MEM_ADDR_W-1:0] a, input mem_pkg::mem_op_e op);
        load_start    = 1'b1;
        load_req.addr = a;
        load_req.op   = op;
        next_cycle();
        load_start = 1'b0;
    endtask

    task automatic push_store(input logic [`MEM_ADDR_W-1:0] a,
                              input logic [`MEM_WORD_W-1:0] data, input mem_pkg::mem_op_e op);
        store_entry.addr = a;
        store_entry.data = data;
        store_entry.op   = op;
        store_push       = 1'b1;
        next_cycle();
        store_push = 1'b0;
    endtask

    task automatic poke_word(input logic [`MEM_ADDR_W-1:0] a,
                             input logic [`MEM_WORD_W-1:0] data);
        bd_we   = 1'b1;
        bd_addr = a;
        bd_data = data;
        next_cycle();
        bd_we = 1'b0;
    endtask

    task automatic wait_result(input logic want_load, output logic [`MEM_WORD_W-1:0] word);
        int   n;
        logic seen;
        seen = 1'b0;
        word = '0;
        n    = 0;
        while (!seen && n < RESULT_LIMIT) begin
            next_cycle();
            n++;
            if (want_load && load_valid) begin
                seen = 1'b1;
                word = load_data;
            end else if (!want_load && inst_valid) begin
                seen = 1'b1;
                word = inst;
            end
        end
        if (!seen) begin
            errors++;
            $display("no %s pulse within %0d cycles of the request",
                     want_load ? "load_valid" : "inst_valid", RESULT_LIMIT);
        end
    endtask

    task automatic expect_no_results(input int ncycles);
        logic seen_inst;
        logic seen_load;
        seen_inst = 1'b0;
        seen_load = 1'b0;
        repeat (ncycles) begin
            next_cycle();
            seen_inst = seen_inst | inst_valid;
            seen_load = seen_load | load_valid;
        end
        check_bit("inst_valid", 1'b0, seen_inst);
        check_bit("load_valid", 1'b0, seen_load);
    endtask

    task automatic reset_state();
        check_bit("ram_we", 1'b0, ram_we);
        check_bit("inst_valid", 1'b0, inst_valid);
        check_bit("load_valid", 1'b0, load_valid);
        check_bit("store_full", 1'b0, store_full);
    endtask

    task automatic store_then_fetch(input mem_pkg::mem_op_e op);
        logic [`MEM_ADDR_W-1:0] a;
        logic [`MEM_WORD_W-1:0] data;
        logic [`MEM_WORD_W-1:0] exp;
        logic [`MEM_WORD_W-1:0] below;
        logic [`MEM_WORD_W-1:0] above;
        logic [`MEM_WORD_W-1:0] got;
        a     = $urandom_range(8, 4080);
        data  = $urandom;
        below = ram_word(a - 4);
        above = ram_word(a + 4);
        exp   = (ram_word(a) & ~byte_mask(op)) | (data & byte_mask(op));
        push_store(a, data, op);
        issue_fetch(a);
        wait_result(1'b0, got);
        check_word($sformatf("ram.mem[%h]", a), exp, ram_word(a));
        check_word($sformatf("ram.mem[%h]", a - 4), below, ram_word(a - 4));
        check_word($sformatf("ram.mem[%h]", a + 4), above, ram_word(a + 4));
        check_word("inst", exp, got);
    endtask

    task automatic store_widths();
        repeat (2) begin
            store_then_fetch(mem_pkg::OP_SB);
            store_then_fetch(mem_pkg::OP_SH);
            store_then_fetch(mem_pkg::OP_SW);
        end
    endtask

    task automatic load_extension();
        mem_pkg::mem_op_e       op;
        logic [`MEM_ADDR_W-1:0] a;
        logic [`MEM_WORD_W-1:0] raw;
        logic [`MEM_WORD_W-1:0] sign_bit;
        logic [`MEM_WORD_W-1:0] got;
        for (int k = 0; k <= 4; k++) begin
            op       = mem_pkg::mem_op_e'(3'(k));
            sign_bit = byte_mask(op) ^ (byte_mask(op) >> 1);
            // once with the top bit set, once clear
            for (int s = 0; s < 2; s++) begin
                a   = $urandom_range(8, 4080);
                raw = $urandom;
                raw = (s == 0) ? (raw | sign_bit) : (raw & ~sign_bit);
                poke_word(a, raw);
                issue_load(a, op);
                wait_result(1'b1, got);
                check_op_result(op, raw, got);
            end
        end
    endtask

    task automatic store_burst();
        logic [`MEM_ADDR_W-1:0] slot_addr [3];
        logic [`MEM_WORD_W-1:0] slot_val [3];
        logic [`MEM_ADDR_W-1:0] base;
        logic [`MEM_WORD_W-1:0] got;
        logic [1:0]             s;
        base = $urandom_range(8, 4000);
        for (int i = 0; i < 3; i++) begin
            s            = 2'(i);
            slot_addr[s] = base + 32'(8 * i);
        end
        // eight stores share three slots and later ones overwrite
        for (int i = 0; i < 8; i++) begin
            s           = 2'(i % 3);
            slot_val[s] = $urandom;
            check_bit("store_full", 1'b0, store_full);
            push_store(slot_addr[s], slot_val[s], mem_pkg::OP_SW);
        end
        // the fetch only runs once the buffer has drained
        issue_fetch(slot_addr[0]);
        wait_result(1'b0, got);
        check_word("inst", slot_val[0], got);
        for (int i = 0; i < 3; i++) begin
            s = 2'(i);
            check_word($sformatf("ram.mem[%h]", slot_addr[s]), slot_val[s],
                       ram_word(slot_addr[s]));
        end
    endtask

    task automatic store_beats_load();
        logic [`MEM_ADDR_W-1:0] a;
        logic [`MEM_WORD_W-1:0] data;
        logic [`MEM_WORD_W-1:0] got;
        a                = $urandom_range(8, 4080);
        data             = ~ram_word(a);
        store_entry.addr = a;
        store_entry.data = data;
        store_entry.op   = mem_pkg::OP_SW;
        store_push       = 1'b1;
        load_req.addr    = a;
        load_req.op      = mem_pkg::OP_LW;
        load_start       = 1'b1;
        next_cycle();
        store_push = 1'b0;
        load_start = 1'b0;
        wait_result(1'b1, got);
        check_op_result(mem_pkg::OP_LW, data, got);
    endtask

    task automatic rollback_cancel();
        logic [`MEM_ADDR_W-1:0] a;
        logic [`MEM_WORD_W-1:0] data;
        logic [`MEM_WORD_W-1:0] got;
        a                = $urandom_range(8, 4080);
        data             = ~ram_word(a);
        store_entry.addr = a;
        store_entry.data = data;
        store_entry.op   = mem_pkg::OP_SW;
        store_push       = 1'b1;
        fetch_req        = 1'b1;
        fetch_pc         = a + 16;
        load_req.addr    = a + 32;
        load_req.op      = mem_pkg::OP_LW;
        load_start       = 1'b1;
        next_cycle();
        store_push = 1'b0;
        fetch_req  = 1'b0;
        load_start = 1'b0;
        rollback   = 1'b1;
        next_cycle();
        rollback = 1'b0;
        expect_no_results(QUIET_CYCLES);
        check_word($sformatf("ram.mem[%h]", a), data, ram_word(a));
        // fetch already on the RAM port when rollback arrives
        issue_fetch(a);
        next_cycle();
        rollback = 1'b1;
        next_cycle();
        rollback = 1'b0;
        expect_no_results(QUIET_CYCLES);
        issue_load(a, mem_pkg::OP_LW);
        wait_result(1'b1, got);
        check_op_result(mem_pkg::OP_LW, data, got);
    endtask

    initial begin
        void'($urandom(9));
        fetch_req   = 1'b0;
        fetch_pc    = '0;
        load_start  = 1'b0;
        load_req    = '0;
        store_push  = 1'b0;
        store_entry = '0;
        rollback    = 1'b0;
        bd_we       = 1'b0;
        bd_addr     = '0;
        bd_data     = '0;

        @(negedge rst);
        next_cycle();

        reset_state();
        store_widths();
        load_extension();
        store_burst();
        store_beats_load();
        rollback_cancel();

        $display("checks: %0d  errors: %0d  cycles: %0d", checks, errors, cycle_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ram_model.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module ram_model #(
    parameter int AW = 12
) (
    input  logic                         clk,
    input  logic [`MEM_ADDR_W-1:0]       addr,
    input  logic                         we,
    input  logic [`MEM_BYTE_W-1:0]       wdata,
    output logic [`MEM_BYTE_W-1:0]       rdata,
    // backdoor word write, bytes land little endian
    input  logic                         bd_we,
    input  logic [`MEM_ADDR_W-1:0]       bd_addr,
    input  logic [3:0][`MEM_BYTE_W-1:0]  bd_data
);

    logic [`MEM_BYTE_W-1:0] mem [2**AW];

    // every address bit feeds the fill byte
    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[AW'(i)] = 8'(i ^ (i >> 4) ^ (i >> 8));
        end
    end

    always @(posedge clk) begin
        if (bd_we) begin
            mem[AW'(bd_addr)]      <= bd_data[0];
            mem[AW'(bd_addr + 1)]  <= bd_data[1];
            mem[AW'(bd_addr + 2)]  <= bd_data[2];
            mem[AW'(bd_addr + 3)]  <= bd_data[3];
        end else if (we) begin
            mem[addr[AW-1:0]] <= wdata;
        end
        // one cycle registered read
        rdata <= mem[addr[AW-1:0]];
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released 1 ns after the last reset edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== design/mem_ctrl_top.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_ctrl_top (
    input  logic                   clk,
    input  logic                   rst,
    // byte wide RAM
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic                   ram_we,
    output logic [`MEM_BYTE_W-1:0] ram_wdata,
    input  logic [`MEM_BYTE_W-1:0] ram_rdata,
    // instruction fetch
    input  logic                   fetch_req,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    output logic                   inst_valid,
    output logic [`MEM_WORD_W-1:0] inst,
    // load unit
    input  logic                   load_start,
    input  mem_pkg::load_req_t     load_req,
    output logic                   load_valid,
    output logic [`MEM_WORD_W-1:0] load_data,
    // committed stores
    input  logic                   store_push,
    input  mem_pkg::store_entry_t  store_entry,
    output logic                   store_full,
    input  logic                   rollback
);

    mem_pkg::store_entry_t  sb_head;
    logic                   sb_not_empty;
    logic                   sb_pop;
    logic                   start;
    mem_pkg::xfer_req_t     xreq;
    logic                   abort;
    logic                   busy;
    logic                   done;
    logic [`MEM_WORD_W-1:0] rdata;

    store_buffer u_store_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (store_push),
        .entry_in  (store_entry),
        .pop       (sb_pop),
        .head      (sb_head),
        .not_empty (sb_not_empty),
        .full      (store_full)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .load_start   (load_start),
        .load_req     (load_req),
        .rollback     (rollback),
        .sb_head      (sb_head),
        .sb_not_empty (sb_not_empty),
        .sb_pop       (sb_pop),
        .start        (start),
        .xreq         (xreq),
        .abort        (abort),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .load_valid   (load_valid),
        .load_data    (load_data)
    );

    ram_sequencer u_ram_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .xreq      (xreq),
        .abort     (abort),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    input  logic                   load_start,
    input  mem_pkg::load_req_t     load_req,
    input  logic                   rollback,
    input  mem_pkg::store_entry_t  sb_head,
    input  logic                   sb_not_empty,
    output logic                   sb_pop,
    output logic                   start,
    output mem_pkg::xfer_req_t     xreq,
    output logic                   abort,
    input  logic                   busy,
    input  logic                   done,
    input  logic [`MEM_WORD_W-1:0] rdata,
    output logic                   inst_valid,
    output logic [`MEM_WORD_W-1:0] inst,
    output logic                   load_valid,
    output logic [`MEM_WORD_W-1:0] load_data
);

    // waiting requests
    logic                   fetch_pend;
    logic [`MEM_ADDR_W-1:0] fetch_addr;
    logic                   load_pend;
    mem_pkg::load_req_t     load_q;

    mem_pkg::xfer_kind_e owner;
    mem_pkg::xfer_kind_e next_kind;
    logic                free;

    function automatic logic [2:0] op_bytes(input mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: op_bytes = 3'd1;
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: op_bytes = 3'd2;
            default: op_bytes = 3'd4;
        endcase
    endfunction

    function automatic logic [`MEM_WORD_W-1:0] extend(
        input mem_pkg::mem_op_e       op,
        input logic [`MEM_WORD_W-1:0] raw
    );
        case (op)
            mem_pkg::OP_LB:  extend = {{24{raw[7]}}, raw[7:0]};
            mem_pkg::OP_LBU: extend = {24'd0, raw[7:0]};
            mem_pkg::OP_LH:  extend = {{16{raw[15]}}, raw[15:0]};
            mem_pkg::OP_LHU: extend = {16'd0, raw[15:0]};
            default:         extend = raw;
        endcase
    endfunction

    assign abort = rollback;

    // busy falls with done and the port is then free
    assign free = !busy;

    // store, then fetch, then load
    always_comb begin
        next_kind = mem_pkg::X_NONE;
        xreq      = '0;
        if (free) begin
            if (sb_not_empty) begin
                next_kind   = mem_pkg::X_STORE;
                xreq.addr   = sb_head.addr;
                xreq.count  = op_bytes(sb_head.op);
                xreq.write  = 1'b1;
                xreq.wdata  = sb_head.data;
            end else if (fetch_pend && !rollback) begin
                next_kind  = mem_pkg::X_FETCH;
                xreq.addr  = fetch_addr;
                xreq.count = 3'd4;
            end else if (load_pend && !rollback) begin
                next_kind  = mem_pkg::X_LOAD;
                xreq.addr  = load_q.addr;
                xreq.count = op_bytes(load_q.op);
            end
        end
    end

    assign start  = next_kind != mem_pkg::X_NONE;
    assign sb_pop = next_kind == mem_pkg::X_STORE;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pend <= 1'b0;
            load_pend  <= 1'b0;
            owner      <= mem_pkg::X_NONE;
            inst_valid <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            load_valid <= 1'b0;
            // results of a cancelled read never leave
            if (done && !rollback) begin
                inst_valid <= owner == mem_pkg::X_FETCH;
                load_valid <= owner == mem_pkg::X_LOAD;
            end
            if (start) begin
                owner <= next_kind;
            end else if (done || (rollback && owner != mem_pkg::X_STORE)) begin
                owner <= mem_pkg::X_NONE;
            end
            if (rollback) begin
                fetch_pend <= 1'b0;
                load_pend  <= 1'b0;
            end else begin
                if (fetch_req) begin
                    fetch_pend <= 1'b1;
                end else if (next_kind == mem_pkg::X_FETCH) begin
                    fetch_pend <= 1'b0;
                end
                if (load_start) begin
                    load_pend <= 1'b1;
                end else if (next_kind == mem_pkg::X_LOAD) begin
                    load_pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            fetch_addr <= fetch_pc;
        end
        // load_q keeps the op until the result is out
        if (load_start) begin
            load_q <= load_req;
        end
        if (done && owner == mem_pkg::X_FETCH) begin
            inst <= rdata;
        end
        if (done && owner == mem_pkg::X_LOAD) begin
            load_data <= extend(load_q.op, rdata);
        end
    end

endmodule

// ==== design/ram_sequencer.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module ram_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  mem_pkg::xfer_req_t     xreq,
    input  logic                   abort,
    output logic                   busy,
    output logic                   done,
    output logic [`MEM_WORD_W-1:0] rdata,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output logic                   ram_we,
    output logic [`MEM_BYTE_W-1:0] ram_wdata,
    input  logic [`MEM_BYTE_W-1:0] ram_rdata
);

    // current transfer
    logic                   wr;
    logic [2:0]             nbytes;
    logic [`MEM_ADDR_W-1:0] base;
    logic [`MEM_WORD_W-1:0] wbuf;
    logic [`MEM_WORD_W-1:0] rbuf;

    // address side and capture side run two cycles apart
    logic [2:0] issue_cnt;
    logic [2:0] cap_cnt;

    // read return pipeline
    logic rd_issue;
    logic rd_ret;
    logic rd_fin;

    logic [`MEM_ADDR_W-1:0] issue_addr;
    logic [`MEM_BYTE_W-1:0] issue_byte;
    logic                   more_bytes;
    logic                   last_issue;

    assign issue_addr = base + {{(`MEM_ADDR_W-3){1'b0}}, issue_cnt};
    assign issue_byte = wbuf[{issue_cnt[1:0], 3'b000} +: `MEM_BYTE_W];
    assign more_bytes = issue_cnt < nbytes;
    assign last_issue = issue_cnt == nbytes - 3'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            wr        <= 1'b0;
            nbytes    <= 3'd0;
            issue_cnt <= 3'd0;
            cap_cnt   <= 3'd0;
            rd_issue  <= 1'b0;
            rd_ret    <= 1'b0;
            rd_fin    <= 1'b0;
            ram_addr  <= '0;
            ram_we    <= 1'b0;
        end else begin
            done   <= 1'b0;
            rd_ret <= rd_issue;
            rd_fin <= 1'b0;
            if (!busy) begin
                if (start) begin
                    // byte 0 goes out on the start edge
                    wr        <= xreq.write;
                    nbytes    <= xreq.count;
                    issue_cnt <= 3'd1;
                    cap_cnt   <= 3'd0;
                    ram_addr  <= xreq.addr;
                    ram_we    <= xreq.write;
                    rd_issue  <= !xreq.write;
                    // single byte store is done at once
                    if (xreq.write && xreq.count == 3'd1) begin
                        done <= 1'b1;
                    end else begin
                        busy <= 1'b1;
                    end
                end else begin
                    ram_addr <= '0;
                    ram_we   <= 1'b0;
                    rd_issue <= 1'b0;
                end
            end else if (abort && !wr) begin
                // drop the read, bytes still in flight are ignored
                busy     <= 1'b0;
                ram_addr <= '0;
                rd_issue <= 1'b0;
                rd_ret   <= 1'b0;
            end else begin
                if (more_bytes) begin
                    ram_addr  <= issue_addr;
                    ram_we    <= wr;
                    rd_issue  <= !wr;
                    issue_cnt <= issue_cnt + 3'd1;
                    if (wr && last_issue) begin
                        done <= 1'b1;
                        busy <= 1'b0;
                    end
                end else begin
                    ram_addr <= '0;
                    ram_we   <= 1'b0;
                    rd_issue <= 1'b0;
                end
                if (rd_ret) begin
                    cap_cnt <= cap_cnt + 3'd1;
                    rd_fin  <= cap_cnt == nbytes - 3'd1;
                end
                if (rd_fin) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            base      <= xreq.addr;
            wbuf      <= xreq.wdata;
            ram_wdata <= xreq.wdata[`MEM_BYTE_W-1:0];
            rbuf      <= '0;
        end else if (busy) begin
            if (more_bytes) begin
                ram_wdata <= issue_byte;
            end
            // little endian, first byte lands in the low lane
            if (rd_ret) begin
                rbuf[{cap_cnt[1:0], 3'b000} +: `MEM_BYTE_W] <= ram_rdata;
            end
            if (rd_fin) begin
                rdata <= rbuf;
            end
        end
    end

endmodule

// ==== design/store_buffer.sv ====
`timescale 1ns/1ps
`include "mem_defs.svh"

module store_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  mem_pkg::store_entry_t entry_in,
    input  logic                  pop,
    output mem_pkg::store_entry_t head,
    output logic                  not_empty,
    output logic                  full
);

    mem_pkg::store_entry_t entries [`SB_DEPTH];

    logic [`SB_IDX_W-1:0] head_ptr;
    logic [`SB_IDX_W-1:0] tail_ptr;
    logic [`SB_IDX_W:0]   count;

    logic do_push;
    logic do_pop;

    // a push into a full buffer is lost
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    assign not_empty = count != '0;
    assign full      = count == (`SB_IDX_W+1)'(`SB_DEPTH);

    // oldest store sits at the head
    assign head = entries[head_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[tail_ptr] <= entry_in;
        end
    end

endmodule

// ==== design/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

    // load and store flavours seen by the controller
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        mem_op_e                op;
    } load_req_t;

    // one store, as committed by the reorder buffer
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] data;
        mem_op_e                op;
    } store_entry_t;

    // count is 1, 2 or 4 bytes
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [2:0]             count;
        logic                   write;
        logic [`MEM_WORD_W-1:0] wdata;
    } xfer_req_t;

    // who owns the RAM port right now
    typedef enum logic [1:0] {
        X_NONE  = 2'd0,
        X_STORE = 2'd1,
        X_FETCH = 2'd2,
        X_LOAD  = 2'd3
    } xfer_kind_e;

endpackage

// ==== design/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte addressed, 32-bit address space
`define MEM_ADDR_W 32

// instruction and data word
`define MEM_WORD_W 32

// the RAM moves one byte per cycle
`define MEM_BYTE_W 8

// committed store queue
`define SB_DEPTH 8
`define SB_IDX_W 3

`endif
